/* Makefile */
VERILATOR ?= verilator
TOP ?= execPipeTb
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert

BIN := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' files.f)
HDRS := sim/execTests.svh

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): files.f $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f files.f

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
+incdir+sim
logic/execPkg.sv
logic/stageIf.sv
logic/regFile.sv
logic/aluCore.sv
logic/branchCond.sv
logic/forwardUnit.sv
logic/execStage.sv
logic/memStage.sv
logic/execPipe.sv
sim/execPipeTb.sv

/* logic/aluCore.sv */
// combinational 16-bit alu with zero, sign, overflow and carry flags
`timescale 1ns/1ps
module aluCore (
   input  execPkg::wordT  a,
   input  execPkg::wordT  b,
   input  execPkg::aluOpT op,
   output execPkg::wordT  result,
   output logic           zero,
   output logic           sign,
   output logic           ovf,
   output logic           carry
);

   logic [execPkg::dataWidth:0] sumExt;
   execPkg::wordT bAdj;
   logic isSub;
   logic [3:0] shamt;

   assign isSub = (op == execPkg::opSub);
   assign shamt = b[3:0];

   // subtract as a + ~b + 1, carry out means no borrow
   assign bAdj = isSub ? ~b : b;
   assign sumExt = {1'b0, a} + {1'b0, bAdj} + {{execPkg::dataWidth{1'b0}}, isSub};

   always_comb begin
      result = '0;
      carry = 1'b0;
      ovf = 1'b0;
      case (op)
         execPkg::opAdd, execPkg::opSub: begin
            result = sumExt[execPkg::dataWidth-1:0];
            carry = sumExt[execPkg::dataWidth];
            // operands of equal sign (after b inversion) giving a flipped sign
            ovf = (a[15] == bAdj[15]) && (sumExt[15] != a[15]);
         end
         execPkg::opAnd: result = a & b;
         execPkg::opOr: result = a | b;
         execPkg::opXor: result = a ^ b;
         execPkg::opShl: result = a << shamt;
         execPkg::opShr: result = a >> shamt;
         // arithmetic shift keeps the sign bit
         execPkg::opSra: result = execPkg::wordT'($signed(a) >>> shamt);
         default: result = '0;
      endcase
   end

   assign zero = (result == '0);
   assign sign = result[execPkg::dataWidth-1];

endmodule

/* logic/branchCond.sv */
// signed condition evaluation from alu flags
`timescale 1ns/1ps
module branchCond (
   input  execPkg::condT cond,
   input  logic          zero,
   input  logic          sign,
   input  logic          ovf,
   output logic          taken
);

   logic lessThan;

   // true signed a < b after a subtraction
   assign lessThan = sign ^ ovf;

   always_comb begin
      case (cond)
         execPkg::condEq: taken = zero;
         execPkg::condNe: taken = !zero;
         execPkg::condLt: taken = lessThan;
         execPkg::condGe: taken = !lessThan;
         execPkg::condLe: taken = lessThan || zero;
         execPkg::condGt: taken = !lessThan && !zero;
         // unused codes never take
         default: taken = 1'b0;
      endcase
   end

endmodule

/* logic/execPipe.sv */
// pipeline top: register file, execute and memory stages, forwarding unit
`timescale 1ns/1ps
module execPipe (
   input  logic            clk,
   input  logic            rstN,
   input  logic            issueValid,
   input  execPkg::kindT   kind,
   input  execPkg::aluOpT  aluOp,
   input  execPkg::condT   cond,
   input  execPkg::regIdxT srcA,
   input  execPkg::regIdxT srcB,
   input  execPkg::regIdxT dst,
   input  execPkg::wordT   imm,
   input  execPkg::wordT   pc,
   output logic            wbValid,
   output execPkg::regIdxT wbReg,
   output execPkg::wordT   wbData,
   output logic            redirectValid,
   output execPkg::wordT   redirectPc
);

   execPkg::wordT rdDataA, rdDataB;
   execPkg::fwdSelT fwdA, fwdB;
   execPkg::regIdxT exSrcA, exSrcB;
   logic exValid;
   execPkg::kindT exKind;

   // stage result bundles
   stageIf exMem ();
   stageIf memWb ();

   // reads use the top-level sources during the issue cycle
   regFile regFile_i (
      .clk(clk),
      .rstN(rstN),
      .rdIdxA(srcA),
      .rdIdxB(srcB),
      .rdDataA(rdDataA),
      .rdDataB(rdDataB),
      .wb(memWb)
   );

   execStage execStage_i (
      .clk(clk),
      .rstN(rstN),
      .issueValid(issueValid),
      .kind(kind),
      .aluOp(aluOp),
      .cond(cond),
      .srcA(srcA),
      .srcB(srcB),
      .dst(dst),
      .imm(imm),
      .pc(pc),
      .rdDataA(rdDataA),
      .rdDataB(rdDataB),
      .fwdA(fwdA),
      .fwdB(fwdB),
      .exSrcA(exSrcA),
      .exSrcB(exSrcB),
      .exValid(exValid),
      .exKind(exKind),
      .wbFwd(memWb),
      .exOut(exMem),
      .redirectValid(redirectValid),
      .redirectPc(redirectPc)
   );

   memStage memStage_i (
      .clk(clk),
      .rstN(rstN),
      .exIn(exMem),
      .wbOut(memWb)
   );

   forwardUnit forwardUnit_i (
      .clk(clk),
      .rstN(rstN),
      .exSrcA(exSrcA),
      .exSrcB(exSrcB),
      .exValid(exValid),
      .exKind(exKind),
      .exMem(exMem),
      .memWb(memWb),
      .fwdA(fwdA),
      .fwdB(fwdB)
   );

   // only writing kinds show up as a writeback
   assign wbValid = memWb.valid && memWb.writes;
   assign wbReg = memWb.destReg;
   assign wbData = memWb.result;

endmodule

/* logic/execPkg.sv */
// shared widths, vector typedefs, instruction kind enum, opcode and condition codes, memory depth
package execPkg;

   // datapath and register file sizes
   localparam int dataWidth = 16;
   localparam int numRegs = 8;
   localparam int regIdxWidth = $clog2(numRegs);

   // data RAM depth, indexed by the low address bits
   localparam int memWords = 256;
   localparam int memIdxWidth = $clog2(memWords);

   typedef logic [dataWidth-1:0] wordT;
   typedef logic [regIdxWidth-1:0] regIdxT;
   typedef logic [memIdxWidth-1:0] memIdxT;
   typedef logic [2:0] aluOpT;
   typedef logic [2:0] condT;
   typedef logic [1:0] fwdSelT;

   // pc distance to the following instruction
   localparam wordT pcStep = 16'd2;

   // alu operations, shift amount taken from b[3:0]
   localparam aluOpT opAdd = 3'd0;
   localparam aluOpT opSub = 3'd1;
   localparam aluOpT opAnd = 3'd2;
   localparam aluOpT opOr = 3'd3;
   localparam aluOpT opXor = 3'd4;
   localparam aluOpT opShl = 3'd5;
   localparam aluOpT opShr = 3'd6;
   localparam aluOpT opSra = 3'd7;

   // signed conditions on a minus b
   localparam condT condEq = 3'd0;
   localparam condT condNe = 3'd1;
   localparam condT condLt = 3'd2;
   localparam condT condGe = 3'd3;
   localparam condT condLe = 3'd4;
   localparam condT condGt = 3'd5;

   // operand source in execute
   localparam fwdSelT fwdNone = 2'd0;
   localparam fwdSelT fwdMem = 2'd1;
   localparam fwdSelT fwdWb = 2'd2;

   typedef enum logic [2:0] {
      kAlu, kAluImm, kSet, kBranch, kJal, kJumpReg, kLoad, kStore
   } kindT;

endpackage

/* logic/execStage.sv */
// execute stage: issue register, forwarding, alu, conditions, pc and link, exMem register
`timescale 1ns/1ps
module execStage (
   input  logic            clk,
   input  logic            rstN,
   input  logic            issueValid,
   input  execPkg::kindT   kind,
   input  execPkg::aluOpT  aluOp,
   input  execPkg::condT   cond,
   input  execPkg::regIdxT srcA,
   input  execPkg::regIdxT srcB,
   input  execPkg::regIdxT dst,
   input  execPkg::wordT   imm,
   input  execPkg::wordT   pc,
   input  execPkg::wordT   rdDataA,
   input  execPkg::wordT   rdDataB,
   input  execPkg::fwdSelT fwdA,
   input  execPkg::fwdSelT fwdB,
   output execPkg::regIdxT exSrcA,
   output execPkg::regIdxT exSrcB,
   output logic            exValid,
   output execPkg::kindT   exKind,
   stageIf.dst             wbFwd,
   stageIf.src             exOut,
   output logic            redirectValid,
   output execPkg::wordT   redirectPc
);

   logic issValid;
   execPkg::kindT issKind;
   execPkg::aluOpT issAluOp;
   execPkg::condT issCond;
   execPkg::regIdxT issSrcA, issSrcB, issDst;
   execPkg::wordT issImm, issPc, issDataA, issDataB;

   execPkg::wordT opA, opB, aluB, aluRes, nextPc, target, result;
   execPkg::aluOpT aluOpSel;
   logic zero, sign, ovf, taken, redirect;

   // pick register data or a later-stage result
   function automatic execPkg::wordT pickOperand(input execPkg::fwdSelT sel,
                                                 input execPkg::wordT regVal,
                                                 input execPkg::wordT memVal,
                                                 input execPkg::wordT wbVal);
      case (sel)
         execPkg::fwdMem: return memVal;
         execPkg::fwdWb: return wbVal;
         default: return regVal;
      endcase
   endfunction

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         issValid <= 1'b0;
      end else begin
         issValid <= issueValid;
      end
   end

   // issued fields, held until the next issue
   always_ff @(posedge clk) begin
      if (issueValid) begin
         issKind <= kind;
         issAluOp <= aluOp;
         issCond <= cond;
         issSrcA <= srcA;
         issSrcB <= srcB;
         issDst <= dst;
         issImm <= imm;
         issPc <= pc;
         issDataA <= rdDataA;
         issDataB <= rdDataB;
      end
   end

   assign exSrcA = issSrcA;
   assign exSrcB = issSrcB;
   assign exValid = issValid;
   assign exKind = issKind;

   // distance 1 reads back our own exMem register
   assign opA = pickOperand(fwdA, issDataA, exOut.result, wbFwd.result);
   assign opB = pickOperand(fwdB, issDataB, exOut.result, wbFwd.result);

   // b input and operation per kind, address kinds always add
   always_comb begin
      aluB = opB;
      aluOpSel = execPkg::opAdd;
      case (issKind)
         execPkg::kAlu: aluOpSel = issAluOp;
         execPkg::kAluImm: begin
            aluB = issImm;
            aluOpSel = issAluOp;
         end
         execPkg::kSet: aluOpSel = execPkg::opSub;
         // branch compares a against zero
         execPkg::kBranch: begin
            aluB = '0;
            aluOpSel = execPkg::opSub;
         end
         execPkg::kLoad, execPkg::kStore, execPkg::kJumpReg: aluB = issImm;
         default: aluOpSel = execPkg::opAdd;
      endcase
   end

   aluCore aluCore_i (
      .a(opA),
      .b(aluB),
      .op(aluOpSel),
      .result(aluRes),
      .zero(zero),
      .sign(sign),
      .ovf(ovf),
      .carry()
   );

   branchCond branchCond_i (
      .cond(issCond),
      .zero(zero),
      .sign(sign),
      .ovf(ovf),
      .taken(taken)
   );

   // pc-relative target and link value
   assign nextPc = issPc + execPkg::pcStep;
   assign target = nextPc + issImm;

   always_comb begin
      case (issKind)
         execPkg::kSet: result = {{(execPkg::dataWidth-1){1'b0}}, taken};
         execPkg::kJal: result = nextPc;
         default: result = aluRes;
      endcase
   end

   assign redirect = issValid && ((issKind == execPkg::kBranch && taken) ||
                                  issKind == execPkg::kJal ||
                                  issKind == execPkg::kJumpReg);

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         exOut.valid <= 1'b0;
         redirectValid <= 1'b0;
      end else begin
         exOut.valid <= issValid;
         redirectValid <= redirect;
      end
   end

   // payload follows valid, no clear needed
   always_ff @(posedge clk) begin
      if (issValid) begin
         exOut.kind <= issKind;
         exOut.destReg <= issDst;
         exOut.writes <= !(issKind == execPkg::kBranch || issKind == execPkg::kStore ||
                           issKind == execPkg::kJumpReg);
         exOut.result <= result;
         exOut.addr <= aluRes;
         exOut.storeData <= opB;
         // jumpReg goes to a plus imm, the rest to next plus imm
         redirectPc <= (issKind == execPkg::kJumpReg) ? aluRes : target;
      end
   end

   aKnownIssue: assert property (@(posedge clk) disable iff (!rstN)
      issValid |-> !$isunknown({issKind, issAluOp}))
      else $error("unknown kind or alu op in execute");

endmodule

/* logic/forwardUnit.sv */
// operand forwarding select from later stages, with load-use hazard check
`timescale 1ns/1ps
module forwardUnit (
   input  logic            clk,
   input  logic            rstN,
   input  execPkg::regIdxT exSrcA,
   input  execPkg::regIdxT exSrcB,
   input  logic            exValid,
   input  execPkg::kindT   exKind,
   stageIf.dst             exMem,
   stageIf.dst             memWb,
   output execPkg::fwdSelT fwdA,
   output execPkg::fwdSelT fwdB
);

   logic memHitA, memHitB;
   logic wbHitA, wbHitB;
   logic usesA, usesB;
   logic loadUse;

   // a producer counts only while valid and writing
   assign memHitA = exValid && exMem.valid && exMem.writes && (exMem.destReg == exSrcA);
   assign memHitB = exValid && exMem.valid && exMem.writes && (exMem.destReg == exSrcB);
   assign wbHitA = exValid && memWb.valid && memWb.writes && (memWb.destReg == exSrcA);
   assign wbHitB = exValid && memWb.valid && memWb.writes && (memWb.destReg == exSrcB);

   // newer instruction in exMem has priority
   assign fwdA = memHitA ? execPkg::fwdMem : (wbHitA ? execPkg::fwdWb : execPkg::fwdNone);
   assign fwdB = memHitB ? execPkg::fwdMem : (wbHitB ? execPkg::fwdWb : execPkg::fwdNone);

   // which sources the kind in execute actually reads
   assign usesA = (exKind != execPkg::kJal);
   assign usesB = (exKind == execPkg::kAlu) || (exKind == execPkg::kSet) ||
                  (exKind == execPkg::kStore);

   // load data is not ready until memWb, so exMem holds only its address
   assign loadUse = (exMem.kind == execPkg::kLoad) &&
                    ((usesA && memHitA) || (usesB && memHitB));

   // issuer must leave a gap after a load before its consumer
   aLoadUse: assert property (@(posedge clk) disable iff (!rstN) !loadUse)
      else $error("load-use at distance 1 on r%0d", exMem.destReg);

endmodule

/* logic/memStage.sv */
// memory stage: data RAM and the memWb register
`timescale 1ns/1ps
module memStage (
   input  logic clk,
   input  logic rstN,
   stageIf.dst  exIn,
   stageIf.src  wbOut
);

   execPkg::wordT mem [execPkg::memWords];
   execPkg::memIdxT idx;
   logic storeEn;

   // word index from the low address bits
   assign idx = exIn.addr[execPkg::memIdxWidth-1:0];
   assign storeEn = exIn.valid && (exIn.kind == execPkg::kStore);

   // RAM reads zero after reset
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < execPkg::memWords; i++) begin
            mem[i] <= '0;
         end
      end else if (storeEn) begin
         mem[idx] <= exIn.storeData;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         wbOut.valid <= 1'b0;
      end else begin
         wbOut.valid <= exIn.valid;
      end
   end

   // combinational read, load data replaces the address result
   always_ff @(posedge clk) begin
      if (exIn.valid) begin
         wbOut.kind <= exIn.kind;
         wbOut.destReg <= exIn.destReg;
         wbOut.writes <= exIn.writes;
         wbOut.result <= (exIn.kind == execPkg::kLoad) ? mem[idx] : exIn.result;
         wbOut.addr <= exIn.addr;
         wbOut.storeData <= exIn.storeData;
      end
   end

   aStoreAddr: assert property (@(posedge clk) disable iff (!rstN)
      storeEn |-> !$isunknown(exIn.addr))
      else $error("store with unknown address");

endmodule

/* logic/regFile.sv */
// eight-entry register file, two read ports, one write port with write-through bypass
`timescale 1ns/1ps
module regFile (
   input  logic            clk,
   input  logic            rstN,
   input  execPkg::regIdxT rdIdxA,
   input  execPkg::regIdxT rdIdxB,
   output execPkg::wordT   rdDataA,
   output execPkg::wordT   rdDataB,
   stageIf.dst             wb
);

   execPkg::wordT regs [execPkg::numRegs];
   logic wrEn;

   // only writing kinds update the file
   assign wrEn = wb.valid && wb.writes;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < execPkg::numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[wb.destReg] <= wb.result;
      end
   end

   // same-cycle write wins over the stored value
   // this covers the distance-3 dependency
   assign rdDataA = (wrEn && (wb.destReg == rdIdxA)) ? wb.result : regs[rdIdxA];
   assign rdDataB = (wrEn && (wb.destReg == rdIdxB)) ? wb.result : regs[rdIdxB];

endmodule

/* logic/stageIf.sv */
// pipeline stage result bundle with producer and consumer views
`timescale 1ns/1ps
interface stageIf;

   // one-cycle strobe per instruction, other fields qualified by it
   logic valid;
   execPkg::kindT kind;

   // destination register and whether this kind writes it
   execPkg::regIdxT destReg;
   logic writes;

   // alu or link result, load data after the memory stage
   execPkg::wordT result;

   // memory address and store data
   execPkg::wordT addr;
   execPkg::wordT storeData;

   // stage that registers the bundle
   modport src (
      output valid,
      output kind,
      output destReg,
      output writes,
      output result,
      output addr,
      output storeData
   );

   // stages and units that look at it
   modport dst (
      input valid,
      input kind,
      input destReg,
      input writes,
      input result,
      input addr,
      input storeData
   );

endinterface

/* sim/execTests.svh */
// directed tests: reset, alu, forwarding, conditions, jumps, memory
task automatic resetTest();
   int errStart;
   int r;
   errStart = errCount;
   repeat (3) begin
      @(negedge clk);
      issueValid = 1'b0;
      if (wbValid !== 1'b0 || redirectValid !== 1'b0) begin
         errCount++;
         $display("strobe seen right after reset");
      end
   end
   // every register reads back as zero
   for (r = 0; r < execPkg::numRegs; r++) begin
      aluImm(execPkg::opAdd, execPkg::regIdxT'(r), execPkg::regIdxT'(r), 16'h0);
   end
   drainPipe();
   reportTest("reset", errStart);
endtask

task automatic aluTest();
   int errStart;
   int rep, op;
   errStart = errCount;
   for (rep = 0; rep < 2; rep++) begin
      loadReg(3'd1, randWord());
      loadReg(3'd2, randWord());
      drainPipe();
      for (op = 0; op < 8; op++) begin
         aluReg(execPkg::aluOpT'(op), 3'd1, 3'd2, execPkg::regIdxT'(3 + op % 5));
      end
      for (op = 0; op < 8; op++) begin
         aluImm(execPkg::aluOpT'(op), 3'd2, execPkg::regIdxT'(3 + op % 5), randWord());
      end
      drainPipe();
   end
   reportTest("alu", errStart);
endtask

task automatic forwardTest();
   int errStart;
   int d, side, f;
   errStart = errCount;
   loadReg(3'd1, randWord());
   loadReg(3'd2, randWord());
   // producer of r4, fillers on r7, consumer at distance d on a or b
   for (d = 1; d <= 3; d++) begin
      for (side = 0; side < 2; side++) begin
         aluImm(execPkg::opAdd, 3'd1, 3'd4, randWord());
         for (f = 1; f < d; f++) aluImm(execPkg::opXor, 3'd1, 3'd7, randWord());
         if (side == 0) aluReg(execPkg::opSub, 3'd4, 3'd2, 3'd5);
         else aluReg(execPkg::opSub, 3'd2, 3'd4, 3'd6);
      end
   end
   // both later stages hold r4, newer one must win
   aluImm(execPkg::opAdd, 3'd1, 3'd4, 16'h0001);
   aluImm(execPkg::opAdd, 3'd4, 3'd4, 16'h0003);
   aluReg(execPkg::opAdd, 3'd4, 3'd4, 3'd5);
   aluReg(execPkg::opSub, 3'd4, 3'd5, 3'd6);
   // chain mixing distances 1, 2 and 3 on both operands
   aluReg(execPkg::opAdd, 3'd2, 3'd2, 3'd3);
   aluReg(execPkg::opXor, 3'd3, 3'd2, 3'd5);
   aluReg(execPkg::opSub, 3'd5, 3'd3, 3'd6);
   aluReg(execPkg::opAdd, 3'd3, 3'd6, 3'd7);
   drainPipe();
   reportTest("forward", errStart);
endtask

task automatic condTest();
   int errStart;
   int p, c;
   execPkg::wordT aVals [8];
   execPkg::wordT bVals [8];
   errStart = errCount;
   // overflowing pairs, equal pair, zero against minus one
   aVals = '{16'h7fff, 16'h8000, 16'h8000, 16'h1234, 16'h0000, 16'h7fff, 16'h0, 16'h0};
   bVals = '{16'h8000, 16'h7fff, 16'h0001, 16'h1234, 16'hffff, 16'hffff, 16'h0, 16'h0};
   for (p = 6; p < 8; p++) begin
      aVals[p] = randWord();
      bVals[p] = randWord();
   end
   for (p = 0; p < 8; p++) begin
      loadReg(3'd1, aVals[p]);
      loadReg(3'd2, bVals[p]);
      for (c = 0; c < 6; c++) begin
         issueInstr(execPkg::kSet, execPkg::opSub, execPkg::condT'(c), 3'd1, 3'd2, 3'd3,
                    16'h0, 16'h0);
      end
      // branch compares r1 against zero
      for (c = 0; c < 6; c++) begin
         issueInstr(execPkg::kBranch, execPkg::opSub, execPkg::condT'(c), 3'd1, 3'd0, 3'd0,
                    randWord() & 16'hfffe, randWord() & 16'hfffe);
      end
   end
   drainPipe();
   reportTest("conditions", errStart);
endtask

task automatic jumpTest();
   int errStart;
   errStart = errCount;
   issueInstr(execPkg::kJal, execPkg::opAdd, execPkg::condEq, 3'd0, 3'd0, 3'd6,
              randWord() & 16'hfffe, randWord() & 16'hfffe);
   // link value used right away
   aluReg(execPkg::opAdd, 3'd6, 3'd6, 3'd7);
   // jump register with its base forwarded at distance 1, then 2
   aluImm(execPkg::opAdd, 3'd1, 3'd2, randWord());
   issueInstr(execPkg::kJumpReg, execPkg::opAdd, execPkg::condEq, 3'd2, 3'd0, 3'd5,
              randWord(), randWord());
   aluImm(execPkg::opXor, 3'd1, 3'd3, randWord());
   aluImm(execPkg::opXor, 3'd1, 3'd4, randWord());
   issueInstr(execPkg::kJumpReg, execPkg::opAdd, execPkg::condEq, 3'd3, 3'd0, 3'd5,
              randWord(), randWord());
   drainPipe();
   reportTest("jumps", errStart);
endtask

task automatic memoryTest();
   int errStart;
   errStart = errCount;
   loadReg(3'd2, 16'h0100);
   loadReg(3'd3, randWord());
   // store data comes from the instruction just before
   issueInstr(execPkg::kStore, execPkg::opAdd, execPkg::condEq, 3'd2, 3'd3, 3'd0,
              16'h0014, 16'h0);
   idleCycles(1);
   issueInstr(execPkg::kLoad, execPkg::opAdd, execPkg::condEq, 3'd2, 3'd0, 3'd4,
              16'h0014, 16'h0);
   // gap before the consumer of the load
   idleCycles(1);
   aluReg(execPkg::opAdd, 3'd4, 3'd4, 3'd5);
   // word 0x77 is never stored to
   issueInstr(execPkg::kLoad, execPkg::opAdd, execPkg::condEq, 3'd2, 3'd0, 3'd6,
              16'h0077, 16'h0);
   drainPipe();
   reportTest("memory", errStart);
endtask

/* sim/execPipeTb.sv */
// testbench top with clock, reset, DUT, reference model, compare tasks, monitor, timeout and report
`timescale 1ns/1ps
module execPipeTb;

   localparam int resetCycles = 16;
   // issue and idle cycles over all tests rounded up from about 230
   localparam int issueBudget = 260;
   localparam int numTests = 6;
   // 3-cycle drain per test plus slack
   localparam int drainCycles = 3;
   localparam int maxCycles = resetCycles + issueBudget + numTests * (drainCycles + 8) + 50;

   logic clk;
   logic rstN;
   logic issueValid;
   execPkg::kindT kind;
   execPkg::aluOpT aluOp;
   execPkg::condT cond;
   execPkg::regIdxT srcA, srcB, dst;
   execPkg::wordT imm, pc;
   logic wbValid;
   execPkg::regIdxT wbReg;
   execPkg::wordT wbData;
   logic redirectValid;
   execPkg::wordT redirectPc;

   // architectural state in program order
   execPkg::wordT refRegs [execPkg::numRegs];
   execPkg::wordT refMem [execPkg::memWords];

   // expected strobes with the cycle they are due in
   int wbDueQ [$];
   execPkg::regIdxT wbRegQ [$];
   execPkg::wordT wbDataQ [$];
   int rdDueQ [$];
   execPkg::wordT rdPcQ [$];

   int cycleCount = 0;
   int errCount = 0;
   int checkCount = 0;
   int testCount = 0;

   execPipe execPipe_i (
      .clk(clk),
      .rstN(rstN),
      .issueValid(issueValid),
      .kind(kind),
      .aluOp(aluOp),
      .cond(cond),
      .srcA(srcA),
      .srcB(srcB),
      .dst(dst),
      .imm(imm),
      .pc(pc),
      .wbValid(wbValid),
      .wbReg(wbReg),
      .wbData(wbData),
      .redirectValid(redirectValid),
      .redirectPc(redirectPc)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   task automatic checkWord(input string name, input execPkg::wordT got,
                            input execPkg::wordT exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic checkReg(input string name, input execPkg::regIdxT got,
                           input execPkg::regIdxT exp);
      checkCount++;
      if (got !== exp) begin
         errCount++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   // alu rule per opcode with the shift amount from b[3:0]
   function automatic execPkg::wordT aluModel(input execPkg::aluOpT op,
                                              input execPkg::wordT a,
                                              input execPkg::wordT b);
      execPkg::wordT r;
      logic [3:0] amt;
      int i;
      amt = b[3:0];
      case (op)
         execPkg::opAdd: return a + b;
         execPkg::opSub: return a - b;
         execPkg::opAnd: return a & b;
         execPkg::opOr: return a | b;
         execPkg::opXor: return a ^ b;
         execPkg::opShl: return a << amt;
         execPkg::opShr: return a >> amt;
         execPkg::opSra: begin
            r = a;
            // shift right one place at a time while copying the sign bit in
            for (i = 0; i < 16; i++) begin
               if (i < amt) r = {r[15], r[15:1]};
            end
            return r;
         end
         default: return '0;
      endcase
   endfunction

   // signed comparison of a against b
   function automatic logic condHolds(input execPkg::condT c, input execPkg::wordT a,
                                      input execPkg::wordT b);
      case (c)
         execPkg::condEq: return a == b;
         execPkg::condNe: return a != b;
         execPkg::condLt: return $signed(a) < $signed(b);
         execPkg::condGe: return $signed(a) >= $signed(b);
         execPkg::condLe: return $signed(a) <= $signed(b);
         execPkg::condGt: return $signed(a) > $signed(b);
         default: return 1'b0;
      endcase
   endfunction

   function automatic execPkg::wordT randWord();
      return execPkg::wordT'($urandom);
   endfunction

   // writeback shows two edges after the rising edge that samples the issue
   task automatic expectWrite(input execPkg::regIdxT d, input execPkg::wordT v);
      refRegs[d] = v;
      wbRegQ.push_back(d);
      wbDataQ.push_back(v);
      wbDueQ.push_back(cycleCount + 3);
   endtask

   task automatic expectRedirect(input execPkg::wordT target);
      rdPcQ.push_back(target);
      rdDueQ.push_back(cycleCount + 2);
   endtask

   // drive one instruction and update the model in program order
   task automatic issueInstr(input execPkg::kindT k, input execPkg::aluOpT op,
                             input execPkg::condT c, input execPkg::regIdxT a,
                             input execPkg::regIdxT b, input execPkg::regIdxT d,
                             input execPkg::wordT immV, input execPkg::wordT pcV);
      execPkg::wordT va, vb, nextV, addrV;
      @(negedge clk);
      issueValid = 1'b1;
      kind = k;
      aluOp = op;
      cond = c;
      srcA = a;
      srcB = b;
      dst = d;
      imm = immV;
      pc = pcV;
      va = refRegs[a];
      vb = refRegs[b];
      nextV = pcV + execPkg::pcStep;
      addrV = va + immV;
      case (k)
         execPkg::kAlu: expectWrite(d, aluModel(op, va, vb));
         execPkg::kAluImm: expectWrite(d, aluModel(op, va, immV));
         execPkg::kSet: expectWrite(d, condHolds(c, va, vb) ? 16'd1 : 16'd0);
         execPkg::kBranch: begin
            if (condHolds(c, va, 16'd0)) expectRedirect(nextV + immV);
         end
         execPkg::kJal: begin
            expectWrite(d, nextV);
            expectRedirect(nextV + immV);
         end
         execPkg::kJumpReg: expectRedirect(addrV);
         execPkg::kLoad: expectWrite(d, refMem[addrV[7:0]]);
         default: refMem[addrV[7:0]] = vb;
      endcase
   endtask

   task automatic aluReg(input execPkg::aluOpT op, input execPkg::regIdxT a,
                         input execPkg::regIdxT b, input execPkg::regIdxT d);
      issueInstr(execPkg::kAlu, op, execPkg::condEq, a, b, d, 16'h0, 16'h0);
   endtask

   task automatic aluImm(input execPkg::aluOpT op, input execPkg::regIdxT a,
                         input execPkg::regIdxT d, input execPkg::wordT immV);
      issueInstr(execPkg::kAluImm, op, execPkg::condEq, a, 3'd0, d, immV, 16'h0);
   endtask

   // clear then set so the register holds v
   task automatic loadReg(input execPkg::regIdxT r, input execPkg::wordT v);
      aluImm(execPkg::opAnd, r, r, 16'h0);
      aluImm(execPkg::opOr, r, r, v);
   endtask

   task automatic idleCycles(input int n);
      repeat (n) begin
         @(negedge clk);
         issueValid = 1'b0;
      end
   endtask

   // stop issuing and wait until every expected strobe has been seen
   task automatic drainPipe();
      @(negedge clk);
      issueValid = 1'b0;
      while (wbDueQ.size() > 0 || rdDueQ.size() > 0) @(negedge clk);
   endtask

   task automatic reportTest(input string name, input int errStart);
      testCount++;
      if (errCount == errStart) $display("test %s: ok", name);
      else $display("test %s: %0d errors", name, errCount - errStart);
   endtask

   `include "execTests.svh"

   always @(posedge clk) begin
      cycleCount++;
      if (cycleCount >= maxCycles) begin
         $display("timeout after %0d cycles, pipeline did not drain", cycleCount);
         $display("Simulation finished: FAIL");
         $finish;
      end
   end

   // registered outputs are stable at the falling edge
   always @(negedge clk) begin
      if (rstN === 1'b1) begin
         if (wbValid === 1'b1) begin
            if (wbDueQ.size() == 0) begin
               errCount++;
               $display("unexpected writeback to r%0d at cycle %0d", wbReg, cycleCount);
            end else begin
               if (wbDueQ[0] != cycleCount) begin
                  errCount++;
                  $display("writeback at cycle %0d, due at cycle %0d", cycleCount, wbDueQ[0]);
               end
               checkReg("wbReg", wbReg, wbRegQ[0]);
               checkWord("wbData", wbData, wbDataQ[0]);
               void'(wbDueQ.pop_front());
               void'(wbRegQ.pop_front());
               void'(wbDataQ.pop_front());
            end
         end else if (wbDueQ.size() > 0 && wbDueQ[0] <= cycleCount) begin
            errCount++;
            $display("writeback to r%0d missing at cycle %0d", wbRegQ[0], wbDueQ[0]);
            void'(wbDueQ.pop_front());
            void'(wbRegQ.pop_front());
            void'(wbDataQ.pop_front());
         end
         if (redirectValid === 1'b1) begin
            if (rdDueQ.size() == 0) begin
               errCount++;
               $display("unexpected redirect at cycle %0d", cycleCount);
            end else begin
               if (rdDueQ[0] != cycleCount) begin
                  errCount++;
                  $display("redirect at cycle %0d, due at cycle %0d", cycleCount, rdDueQ[0]);
               end
               checkWord("redirectPc", redirectPc, rdPcQ[0]);
               void'(rdDueQ.pop_front());
               void'(rdPcQ.pop_front());
            end
         end else if (rdDueQ.size() > 0 && rdDueQ[0] <= cycleCount) begin
            errCount++;
            $display("redirect missing at cycle %0d", rdDueQ[0]);
            void'(rdDueQ.pop_front());
            void'(rdPcQ.pop_front());
         end
      end
   end

   initial begin
      int i;
      void'($urandom(32'h1f1e));
      rstN = 1'b0;
      issueValid = 1'b0;
      kind = execPkg::kAlu;
      aluOp = execPkg::opAdd;
      cond = execPkg::condEq;
      srcA = '0;
      srcB = '0;
      dst = '0;
      imm = '0;
      pc = '0;
      for (i = 0; i < execPkg::numRegs; i++) refRegs[i] = '0;
      for (i = 0; i < execPkg::memWords; i++) refMem[i] = '0;
      repeat (resetCycles) @(negedge clk);
      rstN = 1'b1;
      resetTest();
      aluTest();
      forwardTest();
      condTest();
      jumpTest();
      memoryTest();
      // quiet cycles catch any late strobe
      idleCycles(4);
      $display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errCount);
      if (errCount == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule
